// File: design/flash_macros.svh
`ifndef FLASH_MACROS_SVH
`define FLASH_MACROS_SVH

// sys_clk cycles per SCK half period
`define FLASH_SCK_HALF 5

// SPI NOR opcodes
`define FLASH_OP_WREN 8'h06
`define FLASH_OP_PP   8'h02
`define FLASH_OP_RDSR 8'h05

// Status reads before the poller gives up
`define FLASH_POLL_MAX 64

`endif

// File: design/flash_pkg.sv
`default_nettype none

package flash_pkg;

    typedef logic [23:0] flash_addr_t;
    typedef logic [7:0]  flash_byte_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [1:0]  reg_sel_t;    // Wishbone adr[3:2]

    localparam reg_sel_t REG_ADDR   = 2'd0;
    localparam reg_sel_t REG_DATA   = 2'd1;
    localparam reg_sel_t REG_CTRL   = 2'd2;
    localparam reg_sel_t REG_STATUS = 2'd3;

    // One chip-select frame, fields sent in this order
    typedef struct packed {
        flash_byte_t opcode;
        logic        with_addr;
        flash_addr_t addr;
        logic        with_data;
        flash_byte_t data;
        logic        read_byte;
    } spi_frame_t;

    typedef struct packed {
        logic        busy;
        logic        done;
        logic        poll_error;
        flash_byte_t last_status;
    } ctrl_status_t;

    typedef enum logic [1:0] {PP_IDLE, PP_WREN, PP_PP, PP_FINISH} pp_state_t;
    typedef enum logic [1:0] {POLL_IDLE, POLL_REQ, POLL_CHECK, POLL_GAP} poll_state_t;
    typedef enum logic [1:0] {ENG_IDLE, ENG_SHIFT, ENG_CS_GAP} eng_state_t;

endpackage

`default_nettype wire

// File: design/flash_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module flash_wb_regs
    import flash_pkg::*;
(
    input  logic         sys_clk,
    input  logic         sys_rst_n,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  reg_sel_t     wb_adr,
    input  wb_data_t     wb_dat_w,
    output wb_data_t     wb_dat_r,
    output logic         wb_ack,
    input  ctrl_status_t status,
    output flash_addr_t  prog_addr,
    output flash_byte_t  prog_data,
    output logic         start
);
    logic access;

    // New cycle seen, not yet acknowledged
    assign access = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            start     <= 1'b0;
            prog_addr <= '0;
            prog_data <= '0;
        end else begin
            wb_ack <= access;
            // Start only from an idle controller
            start  <= access && wb_we && (wb_adr == REG_CTRL) && wb_dat_w[0]
                      && !status.busy && !start;
            if (access && wb_we) begin
                case (wb_adr)
                    REG_ADDR: prog_addr <= wb_dat_w[23:0];
                    REG_DATA: prog_data <= wb_dat_w[7:0];
                    default: ;
                endcase
            end
            if (access && !wb_we) begin
                case (wb_adr)
                    REG_ADDR:   wb_dat_r <= {8'd0, prog_addr};
                    REG_DATA:   wb_dat_r <= {24'd0, prog_data};
                    REG_STATUS: wb_dat_r <= {16'd0, status.last_status, 5'd0,
                                             status.poll_error, status.done, status.busy};
                    default:    wb_dat_r <= '0;    // Control reads as zero
                endcase
            end
        end
    end

    // Start never reaches a busy controller
    a_start_only_idle: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        start |-> !status.busy
    );

endmodule

`default_nettype wire

// File: design/flash_pp_seq.sv
`timescale 1ns/100ps
`default_nettype none

`include "flash_macros.svh"

module flash_pp_seq
    import flash_pkg::*;
(
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        start,
    input  flash_addr_t prog_addr,
    input  flash_byte_t prog_data,
    output logic        req,
    output spi_frame_t  frame,
    input  logic        frame_done,
    output logic        pp_done
);
    pp_state_t   state;
    flash_addr_t addr_q;
    flash_byte_t data_q;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= PP_IDLE;
        end else begin
            case (state)
                PP_IDLE:   if (start) state <= PP_WREN;
                PP_WREN:   if (frame_done) state <= PP_PP;
                PP_PP:     if (frame_done) state <= PP_FINISH;
                PP_FINISH: state <= PP_IDLE;
                default:   state <= PP_IDLE;
            endcase
        end
    end

    // Host may rewrite the registers once started
    always_ff @(posedge sys_clk) begin
        if (state == PP_IDLE && start) begin
            addr_q <= prog_addr;
            data_q <= prog_data;
        end
    end

    always_comb begin
        frame        = '0;
        frame.opcode = `FLASH_OP_WREN;
        if (state == PP_PP) begin
            frame.opcode    = `FLASH_OP_PP;
            frame.with_addr = 1'b1;
            frame.addr      = addr_q;
            frame.with_data = 1'b1;
            frame.data      = data_q;
        end
    end

    assign req     = (state == PP_WREN) || (state == PP_PP);
    assign pp_done = (state == PP_FINISH);

endmodule

`default_nettype wire

// File: design/flash_wip_poll.sv
`timescale 1ns/100ps
`default_nettype none

`include "flash_macros.svh"

module flash_wip_poll
    import flash_pkg::*;
(
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        pp_done,
    output logic        req,
    output spi_frame_t  frame,
    input  logic        frame_done,
    input  flash_byte_t rx_byte,
    output logic        poll_finish,
    output logic        timeout,
    output flash_byte_t last_status
);
    localparam int CNT_W = $clog2(`FLASH_POLL_MAX + 1);

    poll_state_t      state;
    logic [CNT_W-1:0] poll_cnt;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= POLL_IDLE;
            poll_cnt    <= '0;
            poll_finish <= 1'b0;
            timeout     <= 1'b0;
            last_status <= '0;
        end else begin
            poll_finish <= 1'b0;
            case (state)
                POLL_IDLE: if (pp_done) begin
                    poll_cnt <= '0;
                    timeout  <= 1'b0;
                    state    <= POLL_REQ;
                end
                POLL_REQ: if (frame_done) begin
                    last_status <= rx_byte;
                    poll_cnt    <= poll_cnt + 1'b1;
                    state       <= POLL_CHECK;
                end
                POLL_CHECK: begin
                    if (!last_status[0]) begin    // WIP cleared
                        poll_finish <= 1'b1;
                        state       <= POLL_IDLE;
                    end else if (poll_cnt == CNT_W'(`FLASH_POLL_MAX)) begin
                        poll_finish <= 1'b1;
                        timeout     <= 1'b1;
                        state       <= POLL_IDLE;
                    end else begin
                        state <= POLL_GAP;
                    end
                end
                POLL_GAP: state <= POLL_REQ;      // Engine still holds cs_n high here
                default:  state <= POLL_IDLE;
            endcase
        end
    end

    assign req   = (state == POLL_REQ);
    assign frame = '{opcode: `FLASH_OP_RDSR, with_addr: 1'b0, addr: '0,
                     with_data: 1'b0, data: '0, read_byte: 1'b1};

endmodule

`default_nettype wire

// File: design/flash_spi_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "flash_macros.svh"

module flash_spi_engine
    import flash_pkg::*;
(
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        pp_req,
    input  spi_frame_t  pp_frame,
    output logic        pp_frame_done,
    input  logic        poll_req,
    input  spi_frame_t  poll_frame,
    output logic        poll_frame_done,
    output flash_byte_t rx_byte,
    input  logic        spi_miso,
    output logic        spi_sck,
    output logic        spi_cs_n,
    output logic        spi_mosi
);
    localparam int HALF   = `FLASH_SCK_HALF;
    localparam int TICK_W = $clog2(2 * HALF);

    eng_state_t        state;
    logic [TICK_W-1:0] tick;
    logic [5:0]        bit_cnt;
    logic [47:0]       shreg;
    logic              owner_poll;
    logic              cur_read;
    flash_byte_t       rx_shift;
    logic              grant_poll;
    spi_frame_t        grant_frame;

    // Opcode, then address, then data, left aligned
    function automatic logic [47:0] pack_frame(input spi_frame_t f);
        logic [47:0] v;
        v = {f.opcode, 40'd0};
        if (f.with_addr && f.with_data)
            v = {f.opcode, f.addr, f.data, 8'd0};
        else if (f.with_addr)
            v = {f.opcode, f.addr, 16'd0};
        else if (f.with_data)
            v = {f.opcode, f.data, 32'd0};
        return v;
    endfunction

    function automatic logic [5:0] frame_bits(input spi_frame_t f);
        return 6'd8 + (f.with_addr ? 6'd24 : 6'd0) + (f.with_data ? 6'd8 : 6'd0)
               + (f.read_byte ? 6'd8 : 6'd0);
    endfunction

    assign grant_poll  = poll_req && !pp_req;    // Sequencer wins a tie
    assign grant_frame = grant_poll ? poll_frame : pp_frame;
    assign spi_mosi    = shreg[47];
    assign rx_byte     = rx_shift;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state           <= ENG_IDLE;
            tick            <= '0;
            bit_cnt         <= '0;
            shreg           <= '0;
            owner_poll      <= 1'b0;
            cur_read        <= 1'b0;
            rx_shift        <= '0;
            spi_cs_n        <= 1'b1;
            spi_sck         <= 1'b0;
            pp_frame_done   <= 1'b0;
            poll_frame_done <= 1'b0;
        end else begin
            pp_frame_done   <= 1'b0;
            poll_frame_done <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    tick <= '0;
                    if (pp_req || poll_req) begin
                        owner_poll <= grant_poll;
                        cur_read   <= grant_frame.read_byte;
                        bit_cnt    <= frame_bits(grant_frame);
                        shreg      <= pack_frame(grant_frame);    // Bit 7 out with cs_n
                        spi_cs_n   <= 1'b0;
                        state      <= ENG_SHIFT;
                    end
                end
                ENG_SHIFT: begin
                    if (tick == TICK_W'(HALF - 1)) begin
                        tick <= '0;
                        if (!spi_sck) begin
                            spi_sck <= 1'b1;
                            if (cur_read)
                                rx_shift <= {rx_shift[6:0], spi_miso};
                        end else begin
                            spi_sck <= 1'b0;
                            if (bit_cnt == 6'd1) begin
                                spi_cs_n        <= 1'b1;
                                shreg           <= '0;
                                pp_frame_done   <= !owner_poll;
                                poll_frame_done <= owner_poll;
                                state           <= ENG_CS_GAP;
                            end else begin
                                shreg   <= {shreg[46:0], 1'b0};
                                bit_cnt <= bit_cnt - 6'd1;
                            end
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                ENG_CS_GAP: begin
                    // Deselect time between frames
                    if (tick == TICK_W'(2 * HALF - 1)) begin
                        tick  <= '0;
                        state <= ENG_IDLE;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Each done goes to a requester still waiting
    a_pp_done_to_req: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        pp_frame_done |-> pp_req
    );

    a_poll_done_to_req: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        poll_frame_done |-> poll_req
    );

    a_sck_idle_low: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        spi_cs_n |-> !spi_sck
    );

endmodule

`default_nettype wire

// File: design/flash_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module flash_ctrl_top
    import flash_pkg::*;
(
    input  logic     sys_clk,
    input  logic     sys_rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  reg_sel_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    output logic     spi_sck,
    output logic     spi_cs_n,
    output logic     spi_mosi,
    input  logic     spi_miso
);
    ctrl_status_t status;
    flash_addr_t  prog_addr;
    flash_byte_t  prog_data;
    flash_byte_t  rx_byte;
    flash_byte_t  last_status;
    spi_frame_t   pp_frame;
    spi_frame_t   poll_frame;
    logic         start;
    logic         pp_req;
    logic         pp_frame_done;
    logic         pp_done;
    logic         poll_req;
    logic         poll_frame_done;
    logic         poll_finish;
    logic         poll_timeout;
    logic         busy;
    logic         done;
    logic         poll_error;

    // Busy spans start to the last status read
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            poll_error <= 1'b0;
        end else if (start) begin
            busy       <= 1'b1;
            done       <= 1'b0;
            poll_error <= 1'b0;
        end else if (poll_finish) begin
            busy       <= 1'b0;
            done       <= 1'b1;
            poll_error <= poll_timeout;
        end
    end

    assign status = '{busy: busy, done: done, poll_error: poll_error, last_status: last_status};

    flash_wb_regs i_regs (
        .sys_clk, .sys_rst_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .status, .prog_addr, .prog_data, .start
    );

    flash_pp_seq i_seq (
        .sys_clk, .sys_rst_n, .start, .prog_addr, .prog_data,
        .req(pp_req), .frame(pp_frame), .frame_done(pp_frame_done), .pp_done
    );

    flash_wip_poll i_poll (
        .sys_clk, .sys_rst_n, .pp_done,
        .req(poll_req), .frame(poll_frame), .frame_done(poll_frame_done), .rx_byte,
        .poll_finish, .timeout(poll_timeout), .last_status
    );

    flash_spi_engine i_engine (
        .sys_clk, .sys_rst_n,
        .pp_req, .pp_frame, .pp_frame_done,
        .poll_req, .poll_frame, .poll_frame_done, .rx_byte,
        .spi_miso, .spi_sck, .spi_cs_n, .spi_mosi
    );

endmodule

`default_nettype wire

// File: tests/flash_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "flash_macros.svh"

module flash_model
    import flash_pkg::*;
(
    input  logic        spi_sck,
    input  logic        spi_cs_n,
    input  logic        spi_mosi,
    output logic        spi_miso,
    input  int          busy_reads,
    output flash_addr_t prog_addr,
    output flash_byte_t prog_data,
    output int          op_count
);
    flash_byte_t op_log [0:1023];    // Opcode of every frame, in order
    logic [47:0] rx_bits;
    int          bit_cnt;
    flash_byte_t opcode;
    int          busy_left;
    flash_byte_t status;
    logic        miso_q;

    assign status   = {7'd0, busy_left != 0};    // WIP only
    assign spi_miso = miso_q & !spi_cs_n;

    initial begin
        prog_addr = '0;
        prog_data = '0;
        op_count  = 0;
        busy_left = 0;
    end

    // Mode 0, mosi taken on rising sck
    always @(posedge spi_sck or negedge spi_cs_n) begin
        if (spi_sck) begin
            rx_bits <= {rx_bits[46:0], spi_mosi};
            bit_cnt <= bit_cnt + 1;
            if (bit_cnt == 7)
                opcode <= {rx_bits[6:0], spi_mosi};
        end else begin
            rx_bits <= '0;
            bit_cnt <= 0;
            opcode  <= '0;
        end
    end

    // Status byte follows the RDSR opcode
    always @(negedge spi_sck) begin
        if (opcode == `FLASH_OP_RDSR && bit_cnt >= 8 && bit_cnt < 16)
            miso_q <= status[3'(15 - bit_cnt)];
        else
            miso_q <= 1'b0;
    end

    // Frame ends at rising cs_n
    always @(posedge spi_cs_n) begin
        if (bit_cnt > 0) begin
            op_log[op_count[9:0]] <= opcode;
            op_count <= op_count + 1;
            if (opcode == `FLASH_OP_PP && bit_cnt == 40) begin
                prog_addr <= rx_bits[31:8];
                prog_data <= rx_bits[7:0];
                busy_left <= busy_reads;    // Program lasts this many polls
            end else if (opcode == `FLASH_OP_RDSR && busy_left > 0) begin
                busy_left <= busy_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_flash_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "flash_macros.svh"

module tb_flash_ctrl
    import flash_pkg::*;
();
    typedef struct packed {
        flash_addr_t addr;
        flash_byte_t data;
        logic [7:0]  busy_reads;
        logic        poll_error;
    } vec_t;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    reg_sel_t    wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    logic        spi_sck;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic        spi_miso;
    int          busy_reads;
    flash_addr_t model_addr;
    flash_byte_t model_data;
    int          op_count;
    logic [31:0] vec_mem [0:63];
    logic [31:0] rng;

    flash_ctrl_top i_dut (
        .sys_clk, .sys_rst_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .spi_sck, .spi_cs_n, .spi_mosi, .spi_miso
    );

    flash_model i_model (
        .spi_sck, .spi_cs_n, .spi_mosi, .spi_miso, .busy_reads,
        .prog_addr(model_addr), .prog_data(model_data), .op_count
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(input string name, input flash_addr_t got, input flash_addr_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_byte(input string name, input flash_byte_t got, input flash_byte_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sys_clk);
    endtask

    // Ack arrives at the next falling edge
    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
            if (n > 16)
                stop_run("Wishbone ack never arrived");
        end while (!wb_ack);
    endtask

    task automatic wb_write(input reg_sel_t sel, input wb_data_t data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = sel;
        wb_dat_w = data;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge sys_clk);
        check_flag("wb_ack", wb_ack, 1'b0);    // Single-cycle ack
    endtask

    task automatic wb_read(input reg_sel_t sel, output wb_data_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = sel;
        wait_ack();
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge sys_clk);
        check_flag("wb_ack", wb_ack, 1'b0);
    endtask

    task automatic run_vector(input vec_t v);
        wb_data_t    rd;
        int          n;
        int          k;
        int          base;
        int          guard;
        int          exp_polls;
        logic        exp_wip;
        flash_byte_t exp_op;
        exp_wip   = int'(v.busy_reads) >= `FLASH_POLL_MAX;
        exp_polls = exp_wip ? `FLASH_POLL_MAX : int'(v.busy_reads) + 1;
        rng = lcg_next(rng);
        wait_cycles(int'(rng[3:0]));
        // Upper bits are junk and must read back as zero
        rng = lcg_next(rng);
        wb_write(REG_ADDR, {rng[31:24], v.addr});
        wb_write(REG_DATA, {rng[23:0], v.data});
        wb_read(REG_ADDR, rd);
        check_word("addr_reg", rd, {8'd0, v.addr});
        wb_read(REG_DATA, rd);
        check_word("data_reg", rd, {24'd0, v.data});
        busy_reads = int'(v.busy_reads);
        base       = op_count;
        wb_write(REG_CTRL, 32'd1);
        wb_write(REG_ADDR, {8'd0, ~v.addr});
        wb_write(REG_DATA, {24'd0, ~v.data});
        rng = lcg_next(rng);
        n   = int'(rng[1:0]) + 1;
        repeat (n) begin
            rng = lcg_next(rng);
            wait_cycles(int'(rng[3:0]));
            wb_read(REG_STATUS, rd);
            check_flag("busy", rd[0], 1'b1);
            check_flag("done", rd[1], 1'b0);
        end
        // Sequencer back in idle, poller still running
        guard = 0;
        while (op_count - base < 2) begin
            @(negedge sys_clk);
            guard++;
            if (guard > 2000)
                stop_run("Page-program frame never reached the flash");
        end
        wb_write(REG_CTRL, 32'd1);    // Dropped while busy
        guard = 0;
        do begin
            wb_read(REG_STATUS, rd);
            guard++;
            if (guard > 20000)
                stop_run("Operation never left busy");
        end while (rd[0]);
        check_flag("done", rd[1], 1'b1);
        check_flag("poll_error", rd[2], v.poll_error);
        check_flag("last_status_wip", rd[8], exp_wip);
        check_byte("last_status", rd[15:8], {7'd0, exp_wip});
        check_addr("model_addr", model_addr, v.addr);
        check_byte("model_data", model_data, v.data);
        check_word("frame_count", wb_data_t'(op_count - base), wb_data_t'(exp_polls + 2));
        for (k = 0; k < exp_polls + 2; k++) begin
            exp_op = (k == 0) ? 8'h06 : (k == 1) ? 8'h02 : 8'h05;
            check_byte($sformatf("frame%0d_opcode", k), i_model.op_log[10'(base + k)], exp_op);
        end
    endtask

    initial begin
        vec_t       v;
        logic [3:0] vi;
        wb_data_t   rd;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        busy_reads = 0;
        rng        = 32'h9ee00123;
        sys_rst_n  = 1'b0;
        $readmemh("tests/flash_vectors.txt", vec_mem);
        repeat (8) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        @(negedge sys_clk);
        // Idle outputs after reset
        check_flag("spi_cs_n", spi_cs_n, 1'b1);
        check_flag("spi_sck", spi_sck, 1'b0);
        check_flag("spi_mosi", spi_mosi, 1'b0);
        check_flag("wb_ack", wb_ack, 1'b0);
        wb_read(REG_STATUS, rd);
        check_word("status_reset", rd, 32'd0);
        vi = '0;
        while (vi < 4'd15 && vec_mem[{vi, 2'd0}] != 32'hffffffff) begin
            v.addr       = vec_mem[{vi, 2'd0}][23:0];
            v.data       = vec_mem[{vi, 2'd1}][7:0];
            v.busy_reads = vec_mem[{vi, 2'd2}][7:0];
            v.poll_error = vec_mem[{vi, 2'd3}][0];
            run_vector(v);
            vi = vi + 4'd1;
        end
        if (vi == 4'd0) begin
            stop_run("No vectors were read from the data file");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/flash_vectors.txt
// address data busy_reads poll_error, all hex, one program operation per line
// An address of ffffffff ends the list
001000 a5 00 0
000000 00 01 0
fffffe 3c 05 0
123456 ff 02 0
abcdef 81 3f 0
7f0001 5a 46 1
0a0b0c 01 40 1
55aa55 c3 00 0
ffffffff 00 00 0

// File: tb.f
+incdir+design
design/flash_pkg.sv
design/flash_wb_regs.sv
design/flash_pp_seq.sv
design/flash_wip_poll.sv
design/flash_spi_engine.sv
design/flash_ctrl_top.sv
tests/flash_model.sv
tests/tb_flash_ctrl.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_flash_ctrl -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"
echo "$out" | grep -qx "TEST OK"
